// File: mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int xlen   = 32;
    localparam int imm_w  = 16;
    localparam int jidx_w = 26;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    localparam word_t reset_pc = 32'h0000_0000;

    // major opcodes
    localparam logic [5:0] op_special = 6'b00_0000;
    localparam logic [5:0] op_j       = 6'b00_0010;
    localparam logic [5:0] op_beq     = 6'b00_0100;
    localparam logic [5:0] op_bne     = 6'b00_0101;
    localparam logic [5:0] op_addi    = 6'b00_1000;
    localparam logic [5:0] op_addiu   = 6'b00_1001;
    localparam logic [5:0] op_slti    = 6'b00_1010;
    localparam logic [5:0] op_sltiu   = 6'b00_1011;
    localparam logic [5:0] op_andi    = 6'b00_1100;
    localparam logic [5:0] op_ori     = 6'b00_1101;
    localparam logic [5:0] op_xori    = 6'b00_1110;
    localparam logic [5:0] op_lui     = 6'b00_1111;
    localparam logic [5:0] op_lw      = 6'b10_0011;
    localparam logic [5:0] op_sw      = 6'b10_1011;

    // special funct codes
    localparam logic [5:0] fn_add  = 6'b10_0000;
    localparam logic [5:0] fn_addu = 6'b10_0001;
    localparam logic [5:0] fn_sub  = 6'b10_0010;
    localparam logic [5:0] fn_subu = 6'b10_0011;
    localparam logic [5:0] fn_and  = 6'b10_0100;
    localparam logic [5:0] fn_or   = 6'b10_0101;
    localparam logic [5:0] fn_xor  = 6'b10_0110;
    localparam logic [5:0] fn_nor  = 6'b10_0111;
    localparam logic [5:0] fn_slt  = 6'b10_1010;
    localparam logic [5:0] fn_sltu = 6'b10_1011;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_instr_t;

    typedef struct packed {
        logic [5:0]       opcode;
        reg_addr_t        rs;
        reg_addr_t        rt;
        logic [imm_w-1:0] imm;
    } i_instr_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [jidx_w-1:0] index;
    } j_instr_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor, alu_nor
    } alu_op_e;

    typedef enum logic [1:0] {npc_plus4, npc_branch, npc_jump} npc_sel_e;

    typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} ext_sel_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_addr;
        word_t     rf_data;
    } retire_t;

endpackage

// File: mips_bus_pkg.sv
package mips_bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic {bus_read, bus_write} bus_kind_e;

    // master to slave
    typedef struct packed {
        logic              arvalid;
        addr_t             araddr;
        logic              awvalid;
        addr_t             awaddr;
        logic              wvalid;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              bready;
        logic              rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [data_w-1:0] rdata;
        logic [1:0]        rresp;
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
    } axil_rsp_t;

endpackage

// File: mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_isa_pkg::word_t   a,
    input  mips_isa_pkg::word_t   b,
    input  mips_isa_pkg::alu_op_e op,
    output mips_isa_pkg::word_t   result,
    output logic                  zero,
    output logic                  overflow
);
    import mips_isa_pkg::*;

    word_t sum;
    word_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_slt:  result = word_t'($signed(a) < $signed(b));
            alu_sltu: result = word_t'(a < b);
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            default:  result = ~(a | b);
        endcase
    end

    // signed overflow when the result sign disagrees with the operands
    always_comb begin
        case (op)
            alu_add: overflow = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
            alu_sub: overflow = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);
            default: overflow = 1'b0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    output mips_isa_pkg::word_t     rs_data,
    output mips_isa_pkg::word_t     rt_data,
    input  logic                    we,
    input  mips_isa_pkg::reg_addr_t waddr,
    input  mips_isa_pkg::word_t     wdata
);
    import mips_isa_pkg::*;

    // $zero has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: mips_pc_unit.sv
`timescale 1ns/1ps

module mips_pc_unit (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    pc_we,
    input  mips_isa_pkg::npc_sel_e                  npc_sel,
    input  mips_isa_pkg::ext_sel_e                  ext_sel,
    input  logic [mips_isa_pkg::imm_w-1:0]          imm16,
    input  logic [mips_isa_pkg::jidx_w-1:0]         instr_index,
    output mips_bus_pkg::addr_t                     pc,
    output mips_isa_pkg::word_t                     imm_ext
);
    import mips_isa_pkg::*;

    word_t pc_plus4;
    word_t next_pc;

    always_comb begin
        case (ext_sel)
            ext_zero: imm_ext = {{(xlen-imm_w){1'b0}}, imm16};
            ext_sign: imm_ext = {{(xlen-imm_w){imm16[imm_w-1]}}, imm16};
            default:  imm_ext = {imm16, {(xlen-imm_w){1'b0}}};
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (npc_sel)
            npc_branch: next_pc = pc_plus4 + {imm_ext[xlen-3:0], 2'b00};
            // region bits come from the delay-slot address
            npc_jump:   next_pc = {pc_plus4[xlen-1:28], instr_index, 2'b00};
            default:    next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (pc_we) begin
            pc <= next_pc;
        end
    end

endmodule

// File: mips_bus_master.sv
`timescale 1ns/1ps

module mips_bus_master (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  mips_bus_pkg::bus_kind_e kind,
    input  mips_bus_pkg::addr_t     addr,
    input  mips_isa_pkg::word_t     wdata,
    output logic                    done,
    output mips_isa_pkg::word_t     rdata,
    output mips_bus_pkg::axil_req_t axil_req,
    input  mips_bus_pkg::axil_rsp_t axil_rsp
);
    import mips_bus_pkg::*;

    typedef enum logic [1:0] {st_idle, st_addr, st_resp} state_e;

    state_e    state;
    bus_kind_e kind_q;
    addr_t     addr_q;
    logic [data_w-1:0] wdata_q;
    logic      arvalid_q;
    logic      awvalid_q;
    logic      wvalid_q;
    logic      aw_ok;
    logic      w_ok;
    logic      rsp_hs;

    // aw and w are accepted independently
    assign aw_ok  = !awvalid_q || axil_rsp.awready;
    assign w_ok   = !wvalid_q || axil_rsp.wready;
    assign rsp_hs = (kind_q == bus_read) ? (axil_rsp.rvalid && axil_req.rready)
                                         : (axil_rsp.bvalid && axil_req.bready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            kind_q    <= bus_read;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: if (req) begin
                    kind_q    <= kind;
                    arvalid_q <= (kind == bus_read);
                    awvalid_q <= (kind == bus_write);
                    wvalid_q  <= (kind == bus_write);
                    state     <= st_addr;
                end
                st_addr: if (kind_q == bus_read) begin
                    if (axil_rsp.arready) begin
                        arvalid_q <= 1'b0;
                        state     <= st_resp;
                    end
                end else begin
                    if (axil_rsp.awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (axil_rsp.wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (aw_ok && w_ok) begin
                        state <= st_resp;
                    end
                end
                default: if (rsp_hs) begin
                    done  <= 1'b1;
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == st_resp && axil_rsp.rvalid && axil_req.rready) begin
            rdata <= axil_rsp.rdata;
        end
    end

    always_comb begin
        axil_req.arvalid = arvalid_q;
        axil_req.araddr  = addr_q;
        axil_req.awvalid = awvalid_q;
        axil_req.awaddr  = addr_q;
        axil_req.wvalid  = wvalid_q;
        axil_req.wdata   = wdata_q;
        axil_req.wstrb   = '1;
        axil_req.bready  = (state == st_resp) && (kind_q == bus_write);
        axil_req.rready  = (state == st_resp) && (kind_q == bus_read);
    end

endmodule

// File: mips_ctrl.sv
`timescale 1ns/1ps

module mips_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             bus_done,
    input  mips_isa_pkg::word_t              bus_rdata,
    input  mips_isa_pkg::word_t              rs_data,
    input  mips_isa_pkg::word_t              rt_data,
    input  mips_isa_pkg::word_t              alu_result,
    input  logic                             alu_zero,
    input  logic                             alu_overflow,
    input  mips_bus_pkg::addr_t              pc,
    input  mips_isa_pkg::word_t              imm_ext,
    output logic                             bus_req,
    output mips_bus_pkg::bus_kind_e          bus_kind,
    output mips_bus_pkg::addr_t              bus_addr,
    output mips_isa_pkg::word_t              bus_wdata,
    output mips_isa_pkg::reg_addr_t          rs_addr,
    output mips_isa_pkg::reg_addr_t          rt_addr,
    output logic                             rf_we,
    output mips_isa_pkg::reg_addr_t          rf_waddr,
    output mips_isa_pkg::word_t              rf_wdata,
    output mips_isa_pkg::alu_op_e            alu_op,
    output mips_isa_pkg::word_t              alu_b,
    output mips_isa_pkg::ext_sel_e           ext_sel,
    output mips_isa_pkg::npc_sel_e           npc_sel,
    output logic                             pc_we,
    output logic [mips_isa_pkg::jidx_w-1:0]  instr_index,
    output logic [mips_isa_pkg::imm_w-1:0]   imm16,
    output mips_isa_pkg::retire_t            retire,
    output logic                             int_overflow
);
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;

    typedef enum logic [2:0] {st_fetch, st_decode, st_exec, st_mem, st_wb} state_e;
    typedef enum logic [2:0] {
        cls_alu, cls_lui, cls_lw, cls_sw, cls_beq, cls_bne, cls_j, cls_nop
    } cls_e;

    typedef struct packed {
        cls_e      cls;
        alu_op_e   op;
        logic      use_imm;
        ext_sel_e  ext;
        logic      trap;
        reg_addr_t dest;
    } dec_t;

    state_e   state;
    word_t    ir;
    word_t    load_q;
    word_t    alu_q;
    logic     ovf_q;
    logic     pending;
    dec_t     dec;
    dec_t     dec_q;
    r_instr_t ir_r;
    i_instr_t ir_i;
    j_instr_t ir_j;
    logic     last;

    assign ir_r = ir;
    assign ir_i = ir;
    assign ir_j = ir;

    always_comb begin
        dec = '{cls: cls_nop, op: alu_add, use_imm: 1'b1, ext: ext_sign, trap: 1'b0,
                dest: ir_i.rt};
        case (ir_r.opcode)
            op_special: begin
                dec.cls     = (ir_r.shamt == '0) ? cls_alu : cls_nop;
                dec.use_imm = 1'b0;
                dec.dest    = ir_r.rd;
                case (ir_r.funct)
                    fn_add:  dec.trap = 1'b1;
                    fn_addu: dec.op = alu_add;
                    fn_sub:  {dec.op, dec.trap} = {alu_sub, 1'b1};
                    fn_subu: dec.op = alu_sub;
                    fn_and:  dec.op = alu_and;
                    fn_or:   dec.op = alu_or;
                    fn_xor:  dec.op = alu_xor;
                    fn_nor:  dec.op = alu_nor;
                    fn_slt:  dec.op = alu_slt;
                    fn_sltu: dec.op = alu_sltu;
                    default: dec.cls = cls_nop;
                endcase
            end
            op_addi:  {dec.cls, dec.trap} = {cls_alu, 1'b1};
            op_addiu: dec.cls = cls_alu;
            op_slti:  {dec.cls, dec.op} = {cls_alu, alu_slt};
            op_sltiu: {dec.cls, dec.op} = {cls_alu, alu_sltu};
            op_andi:  {dec.cls, dec.op, dec.ext} = {cls_alu, alu_and, ext_zero};
            op_ori:   {dec.cls, dec.op, dec.ext} = {cls_alu, alu_or, ext_zero};
            op_xori:  {dec.cls, dec.op, dec.ext} = {cls_alu, alu_xor, ext_zero};
            op_lui:   if (ir_i.rs == '0) {dec.cls, dec.ext} = {cls_lui, ext_upper};
            op_lw:    dec.cls = cls_lw;
            op_sw:    dec.cls = cls_sw;
            // compare rs and rt through the subtractor
            op_beq:   {dec.cls, dec.op, dec.use_imm} = {cls_beq, alu_sub, 1'b0};
            op_bne:   {dec.cls, dec.op, dec.use_imm} = {cls_bne, alu_sub, 1'b0};
            op_j:     dec.cls = cls_j;
            default:  dec.cls = cls_nop;
        endcase
    end

    // final cycle of each instruction
    always_comb begin
        case (state)
            st_exec: last = dec_q.cls inside {cls_beq, cls_bne, cls_j, cls_nop};
            st_mem:  last = (dec_q.cls == cls_sw) && bus_done;
            st_wb:   last = 1'b1;
            default: last = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_fetch;
            dec_q   <= '0;
            ovf_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (bus_req) begin
                pending <= 1'b1;
            end else if (bus_done) begin
                pending <= 1'b0;
            end
            case (state)
                st_fetch:  if (bus_done) state <= st_decode;
                st_decode: begin
                    dec_q <= dec;
                    state <= st_exec;
                end
                st_exec: begin
                    ovf_q <= alu_overflow && dec_q.trap;
                    case (dec_q.cls)
                        cls_alu, cls_lui: state <= st_wb;
                        cls_lw, cls_sw:   state <= st_mem;
                        default:          state <= st_fetch;
                    endcase
                end
                st_mem: if (bus_done) state <= (dec_q.cls == cls_sw) ? st_fetch : st_wb;
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && bus_done) begin
            ir <= bus_rdata;
        end
        if (state == st_exec) begin
            alu_q <= alu_result;
        end
        if (state == st_mem && bus_done) begin
            load_q <= bus_rdata;
        end
    end

    // one request pulse per access, payload held until done
    assign bus_req   = (state == st_fetch || state == st_mem) && !pending;
    assign bus_kind  = (state == st_mem && dec_q.cls == cls_sw) ? bus_write : bus_read;
    assign bus_addr  = (state == st_mem) ? alu_q : pc;
    assign bus_wdata = rt_data;

    assign rs_addr     = ir_r.rs;
    assign rt_addr     = ir_r.rt;
    assign imm16       = ir_i.imm;
    assign instr_index = ir_j.index;
    assign alu_op      = dec_q.op;
    assign alu_b       = dec_q.use_imm ? imm_ext : rt_data;
    assign ext_sel     = dec_q.ext;

    always_comb begin
        npc_sel = npc_plus4;
        if (state == st_exec) begin
            case (dec_q.cls)
                cls_beq: npc_sel = alu_zero ? npc_branch : npc_plus4;
                cls_bne: npc_sel = alu_zero ? npc_plus4 : npc_branch;
                cls_j:   npc_sel = npc_jump;
                default: npc_sel = npc_plus4;
            endcase
        end
    end

    always_comb begin
        case (dec_q.cls)
            cls_lw:  rf_wdata = load_q;
            cls_lui: rf_wdata = imm_ext;
            default: rf_wdata = alu_q;
        endcase
    end

    assign rf_waddr     = dec_q.dest;
    assign rf_we        = (state == st_wb) && !ovf_q;
    assign int_overflow = (state == st_wb) && ovf_q;
    assign pc_we        = last;

    always_comb begin
        retire.valid   = last;
        retire.pc      = pc;
        retire.rf_we   = rf_we;
        retire.rf_addr = rf_waddr;
        retire.rf_data = rf_wdata;
    end

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                    clk,
    input  logic                    rst,
    output mips_bus_pkg::axil_req_t axil_req,
    input  mips_bus_pkg::axil_rsp_t axil_rsp,
    output mips_isa_pkg::retire_t   retire,
    output logic                    int_overflow
);
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;

    logic      bus_req;
    logic      bus_done;
    bus_kind_e bus_kind;
    addr_t     bus_addr;
    word_t     bus_wdata;
    word_t     bus_rdata;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t rf_waddr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     rf_wdata;
    logic      rf_we;

    alu_op_e   alu_op;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    logic      alu_overflow;

    ext_sel_e  ext_sel;
    npc_sel_e  npc_sel;
    logic      pc_we;
    addr_t     pc;
    word_t     imm_ext;
    logic [imm_w-1:0]  imm16;
    logic [jidx_w-1:0] instr_index;

    mips_ctrl mips_ctrl_inst (
        .clk, .rst, .bus_done, .bus_rdata, .rs_data, .rt_data, .alu_result, .alu_zero,
        .alu_overflow, .pc, .imm_ext, .bus_req, .bus_kind, .bus_addr, .bus_wdata,
        .rs_addr, .rt_addr, .rf_we, .rf_waddr, .rf_wdata, .alu_op, .alu_b, .ext_sel,
        .npc_sel, .pc_we, .instr_index, .imm16, .retire, .int_overflow
    );

    mips_regfile mips_regfile_inst (
        .clk, .rst, .rs_addr, .rt_addr, .rs_data, .rt_data,
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    mips_alu mips_alu_inst (
        .a(rs_data), .b(alu_b), .op(alu_op),
        .result(alu_result), .zero(alu_zero), .overflow(alu_overflow)
    );

    mips_pc_unit mips_pc_unit_inst (
        .clk, .rst, .pc_we, .npc_sel, .ext_sel, .imm16, .instr_index, .pc, .imm_ext
    );

    mips_bus_master mips_bus_master_inst (
        .clk, .rst, .req(bus_req), .kind(bus_kind), .addr(bus_addr), .wdata(bus_wdata),
        .done(bus_done), .rdata(bus_rdata), .axil_req, .axil_rsp
    );

endmodule

// File: tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// reference state, kept apart from the memory the DUT sees
logic [31:0] m_regs [0:31];
logic [31:0] m_mem [0:2047];
logic [31:0] m_pc;

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = 32'h0;
    end
    m_pc = 32'h0;
endtask

task automatic step_model(output retire_t exp, output logic ovf, output int st_idx);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] npc;
    logic [31:0] ea;
    logic [32:0] wide;
    ins = m_mem[m_pc[12:2]];
    a = m_regs[ins[25:21]];
    b = m_regs[ins[20:16]];
    imm_s = {{16{ins[15]}}, ins[15:0]};
    imm_z = {16'h0, ins[15:0]};
    npc = m_pc + 32'd4;
    ea = a + imm_s;
    exp = '0;
    exp.valid = 1'b1;
    exp.pc = m_pc;
    exp.rf_addr = ins[20:16];
    ovf = 1'b0;
    st_idx = -1;
    case (ins[31:26])
        op_special: begin
            exp.rf_addr = ins[15:11];
            exp.rf_we = (ins[10:6] == 5'd0);
            case (ins[5:0])
                fn_add, fn_addu: begin
                    wide = {a[31], a} + {b[31], b};
                    exp.rf_data = wide[31:0];
                    ovf = (ins[5:0] == fn_add) && (wide[32] != wide[31]);
                end
                fn_sub, fn_subu: begin
                    wide = {a[31], a} - {b[31], b};
                    exp.rf_data = wide[31:0];
                    ovf = (ins[5:0] == fn_sub) && (wide[32] != wide[31]);
                end
                fn_and:  exp.rf_data = a & b;
                fn_or:   exp.rf_data = a | b;
                fn_xor:  exp.rf_data = a ^ b;
                fn_nor:  exp.rf_data = ~(a | b);
                fn_slt:  exp.rf_data = {31'h0, $signed(a) < $signed(b)};
                fn_sltu: exp.rf_data = {31'h0, a < b};
                default: exp.rf_we = 1'b0;
            endcase
            ovf = ovf && exp.rf_we;
        end
        op_addi, op_addiu: begin
            wide = {a[31], a} + {imm_s[31], imm_s};
            exp.rf_we = 1'b1;
            exp.rf_data = wide[31:0];
            ovf = (ins[31:26] == op_addi) && (wide[32] != wide[31]);
        end
        op_slti:  {exp.rf_we, exp.rf_data} = {1'b1, 31'h0, $signed(a) < $signed(imm_s)};
        op_sltiu: {exp.rf_we, exp.rf_data} = {1'b1, 31'h0, a < imm_s};
        op_andi:  {exp.rf_we, exp.rf_data} = {1'b1, a & imm_z};
        op_ori:   {exp.rf_we, exp.rf_data} = {1'b1, a | imm_z};
        op_xori:  {exp.rf_we, exp.rf_data} = {1'b1, a ^ imm_z};
        op_lui:   {exp.rf_we, exp.rf_data} = {ins[25:21] == 5'd0, ins[15:0], 16'h0};
        op_lw:    {exp.rf_we, exp.rf_data} = {1'b1, m_mem[ea[12:2]]};
        op_sw: begin
            m_mem[ea[12:2]] = b;
            st_idx = int'(ea[12:2]);
        end
        op_beq:   if (a == b) npc = npc + (imm_s << 2);
        op_bne:   if (a != b) npc = npc + (imm_s << 2);
        op_j:     npc = {npc[31:28], ins[25:0], 2'b00};
        default:  exp.rf_we = 1'b0;
    endcase
    // an overflowing add leaves its destination alone
    if (ovf) begin
        exp.rf_we = 1'b0;
    end
    if (exp.rf_we && exp.rf_addr != 5'd0) begin
        m_regs[exp.rf_addr] = exp.rf_data;
    end
    m_pc = npc;
endtask

// program at word 0 upward, data region at byte 0x1000
task automatic gen_program(input int len);
    logic [31:0] w;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [15:0] imm;
    logic [5:0] fns [0:9];
    logic [5:0] iops [0:6];
    int k;
    fns = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    iops = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori};
    for (int i = 0; i < 2048; i++) begin
        w = (i >= 1024) ? $urandom : 32'h0;
        mem[i] = w;
        m_mem[i] = w;
    end
    for (int i = 0; i < len; i++) begin
        rs = 5'($urandom % 8);
        rt = 5'($urandom % 8);
        rd = 5'($urandom % 8);
        imm = 16'($urandom);
        k = 1 + int'($urandom % 4);
        case ($urandom % 16)
            0, 1, 2, 3, 4: w = {op_special, rs, rt, rd, 5'd0, fns[$urandom % 10]};
            5, 6, 7, 8:    w = {iops[$urandom % 7], rs, rt, imm};
            9, 10:         w = {op_lui, 5'd0, rt, imm};
            11:            w = {op_sw, 5'd0, rt, 16'(32'h1000 + 4 * ($urandom % 16))};
            12:            w = {op_lw, 5'd0, rt, 16'(32'h1000 + 4 * ($urandom % 16))};
            13:            w = {op_beq, rs, rt, 16'(k)};
            14:            w = {op_bne, rs, rt, 16'(k)};
            default:       w = {op_j, 26'(i + k)};
        endcase
        mem[i] = w;
        m_mem[i] = w;
    end
endtask

`endif

// File: tb_mips.sv
`timescale 1ns/1ps

module tb_mips;
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;

    logic      clk;
    logic      rst = 1'b1;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp = '0;
    retire_t   retire;
    logic      int_overflow;

    logic [31:0] mem [0:2047];
    int   errors = 0;
    int   checks = 0;
    int   ar_wait, r_wait, aw_wait, w_wait, b_wait;
    logic r_busy, aw_done, w_done;
    logic [31:0] wr_addr, wr_data;
    logic first_fetch = 1'b0;
    bit   alive = 1'b1;

    `include "tb_mips_model.svh"

    mips_core mips_core_inst (.clk, .rst, .axil_req, .axil_rsp, .retire, .int_overflow);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory responder, 0 to 3 idle cycles before each ready and response
    always @(posedge clk) begin
        if (rst) begin
            axil_rsp <= '0;
            {r_busy, aw_done, w_done} <= 3'b000;
            {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
            first_fetch <= 1'b1;
        end else begin
            if (axil_req.arvalid && axil_rsp.arready) begin
                if (first_fetch) begin
                    compare("araddr", axil_req.araddr, 32'h0);
                    first_fetch <= 1'b0;
                end
                axil_rsp.arready <= 1'b0;
                axil_rsp.rdata <= mem[axil_req.araddr[12:2]];
                r_busy <= 1'b1;
                ar_wait <= int'($urandom % 4);
            end else if (axil_req.arvalid && !r_busy) begin
                if (ar_wait == 0) axil_rsp.arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (axil_rsp.rvalid && axil_req.rready) begin
                axil_rsp.rvalid <= 1'b0;
                r_busy <= 1'b0;
                r_wait <= int'($urandom % 4);
            end else if (r_busy && !axil_rsp.rvalid) begin
                if (r_wait == 0) axil_rsp.rvalid <= 1'b1;
                else r_wait <= r_wait - 1;
            end
            if (axil_req.awvalid && axil_rsp.awready) begin
                axil_rsp.awready <= 1'b0;
                aw_done <= 1'b1;
                wr_addr <= axil_req.awaddr;
                aw_wait <= int'($urandom % 4);
            end else if (axil_req.awvalid && !aw_done) begin
                if (aw_wait == 0) axil_rsp.awready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (axil_req.wvalid && axil_rsp.wready) begin
                compare("wstrb", 32'(axil_req.wstrb), 32'h0000_000f);
                axil_rsp.wready <= 1'b0;
                w_done <= 1'b1;
                wr_data <= axil_req.wdata;
                w_wait <= int'($urandom % 4);
            end else if (axil_req.wvalid && !w_done) begin
                if (w_wait == 0) axil_rsp.wready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (axil_rsp.bvalid && axil_req.bready) begin
                axil_rsp.bvalid <= 1'b0;
                {aw_done, w_done} <= 2'b00;
                b_wait <= int'($urandom % 4);
            end else if (aw_done && w_done && !axil_rsp.bvalid) begin
                if (b_wait == 0) begin
                    mem[wr_addr[12:2]] = wr_data;
                    axil_rsp.bvalid <= 1'b1;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_retire(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 100 && !ok; n++) begin
            @(negedge clk);
            ok = retire.valid;
        end
    endtask

    task automatic run_program(input string name, input int len, input int count);
        retire_t exp;
        logic    exp_ovf;
        int      st_idx;
        bit      ok;
        int      start_err;
        int      n_ovf;
        int      n_store;
        int      n_done;
        start_err = errors;
        {n_ovf, n_store, n_done} = '0;
        @(posedge clk);
        rst <= 1'b1;
        gen_program(len);
        reset_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare("retire.valid", 32'(retire.valid), 32'h0);
        compare("arvalid", 32'(axil_req.arvalid), 32'h0);
        compare("awvalid", 32'(axil_req.awvalid), 32'h0);
        compare("wvalid", 32'(axil_req.wvalid), 32'h0);
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < count && alive; i++) begin
            wait_retire(ok);
            if (!ok) begin
                $display("%s: no instruction retired within 100 cycles after retire %0d",
                         name, i);
                errors++;
                alive = 1'b0;
            end else begin
                step_model(exp, exp_ovf, st_idx);
                compare("retire.pc", retire.pc, exp.pc);
                compare("retire.rf_we", 32'(retire.rf_we), 32'(exp.rf_we));
                compare("int_overflow", 32'(int_overflow), 32'(exp_ovf));
                if (exp.rf_we) begin
                    compare("retire.rf_addr", 32'(retire.rf_addr), 32'(exp.rf_addr));
                    compare("retire.rf_data", retire.rf_data, exp.rf_data);
                end
                if (st_idx >= 0) begin
                    compare("mem", mem[st_idx], m_mem[st_idx]);
                    n_store++;
                end
                if (exp_ovf) n_ovf++;
                n_done++;
            end
        end
        $display("test %s: %0d retires, %0d overflows, %0d stores, %0d errors",
                 name, n_done, n_ovf, n_store, errors - start_err);
    endtask

    initial begin
        void'($urandom(32'h584096c7));
        run_program("random_long", 240, 200);
        if (alive) run_program("random_short", 120, 200);
        if (alive) run_program("random_dense", 240, 200);
        $display("done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
mips_isa_pkg.sv
mips_bus_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_pc_unit.sv
mips_bus_master.sv
mips_ctrl.sv
mips_core.sv
tb_mips.sv

// File: Makefile
SRCS := $(filter-out +incdir+%,$(shell cat build.f))

obj_dir/Vtb_mips: build.f $(SRCS) tb_mips_model.svh
	verilator --binary --timing -f build.f --top-module tb_mips -o Vtb_mips

.PHONY: run clean

run: obj_dir/Vtb_mips
	@out="$$(./obj_dir/Vtb_mips)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
